// File: hw/img_pkg.sv
package img_pkg;

    // frame geometry
    localparam int unsigned IMG_COLS = 16;
    localparam int unsigned IMG_ROWS = 12;

    // grayscale sample width
    localparam int unsigned PIXEL_W = 8;

    // counter widths, sized for the geometry above
    localparam int unsigned COL_W = 4;
    localparam int unsigned ROW_W = 4;

    // one grayscale pixel
    typedef logic [PIXEL_W-1:0] pixel_t;

    // column index within a row
    typedef logic [COL_W-1:0] col_t;

    // row index within a frame
    typedef logic [ROW_W-1:0] row_t;

endpackage

// File: hw/lbp_pkg.sv
package lbp_pkg;

    // neighbors around the center pixel
    localparam int unsigned NEIGHBORS = 8;

    // nine pixels of 255 reach 2295, so 12 bits
    localparam int unsigned SUM_W = 12;

    typedef logic [NEIGHBORS-1:0] code_t;

    typedef logic [SUM_W-1:0] sum_t;

    // neighbor times nine, compared against the window sum
    typedef logic [SUM_W-1:0] scaled_t;

    // code bit position of each neighbor
    localparam int unsigned NB_E  = 0;
    localparam int unsigned NB_NE = 1;
    localparam int unsigned NB_N  = 2;
    localparam int unsigned NB_NW = 3;
    localparam int unsigned NB_W  = 4;
    localparam int unsigned NB_SW = 5;
    localparam int unsigned NB_S  = 6;
    localparam int unsigned NB_SE = 7;

endpackage

// File: hw/row_buffer.sv
`timescale 1ns/1ps

module row_buffer (
    input  logic            clk,
    input  logic            reset_i,
    input  img_pkg::pixel_t pix_i,
    input  logic            done_i,
    output img_pkg::pixel_t col_top_o,
    output img_pkg::pixel_t col_mid_o,
    output img_pkg::pixel_t col_bot_o,
    output logic            col_done_o
);

    // two rows back and one row back
    img_pkg::pixel_t top_mem [0:img_pkg::IMG_COLS-1];
    img_pkg::pixel_t mid_mem [0:img_pkg::IMG_COLS-1];

    img_pkg::col_t   wr_ptr;
    img_pkg::pixel_t old_top;
    img_pkg::pixel_t old_mid;

    assign old_top = top_mem[wr_ptr];
    assign old_mid = mid_mem[wr_ptr];

    // shared column pointer, moves once per pixel
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
        end else if (done_i) begin
            if (wr_ptr == img_pkg::col_t'(img_pkg::IMG_COLS - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // middle row ages into the top row, new pixel takes its place
    always_ff @(posedge clk) begin
        if (done_i) begin
            top_mem[wr_ptr] <= old_mid;
            mid_mem[wr_ptr] <= pix_i;
            col_top_o       <= old_top;
            col_mid_o       <= old_mid;
            col_bot_o       <= pix_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            col_done_o <= 1'b0;
        end else begin
            col_done_o <= done_i;
        end
    end

endmodule

// File: hw/window_3x3.sv
`timescale 1ns/1ps

module window_3x3 (
    input  logic            clk,
    input  logic            reset_i,
    input  img_pkg::pixel_t col_top_i,
    input  img_pkg::pixel_t col_mid_i,
    input  img_pkg::pixel_t col_bot_i,
    input  logic            col_done_i,
    output img_pkg::pixel_t win_nw_o,
    output img_pkg::pixel_t win_n_o,
    output img_pkg::pixel_t win_ne_o,
    output img_pkg::pixel_t win_w_o,
    output img_pkg::pixel_t win_c_o,
    output img_pkg::pixel_t win_e_o,
    output img_pkg::pixel_t win_sw_o,
    output img_pkg::pixel_t win_s_o,
    output img_pkg::pixel_t win_se_o,
    output logic            win_done_o,
    output logic            win_last_o
);

    // index 0 is west, 2 is east (newest column)
    img_pkg::pixel_t top_q [0:2];
    img_pkg::pixel_t mid_q [0:2];
    img_pkg::pixel_t bot_q [0:2];

    // position of the column being shifted in
    img_pkg::col_t col_cnt;
    img_pkg::row_t row_cnt;

    logic last_col;
    logic last_row;
    logic interior;

    assign last_col = (col_cnt == img_pkg::col_t'(img_pkg::IMG_COLS - 1));
    assign last_row = (row_cnt == img_pkg::row_t'(img_pkg::IMG_ROWS - 1));
    // a full window needs two rows and two columns already seen
    assign interior = (row_cnt >= img_pkg::row_t'(2)) && (col_cnt >= img_pkg::col_t'(2));

    always_ff @(posedge clk) begin
        if (col_done_i) begin
            top_q[0] <= top_q[1];
            top_q[1] <= top_q[2];
            top_q[2] <= col_top_i;
            mid_q[0] <= mid_q[1];
            mid_q[1] <= mid_q[2];
            mid_q[2] <= col_mid_i;
            bot_q[0] <= bot_q[1];
            bot_q[1] <= bot_q[2];
            bot_q[2] <= col_bot_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            col_cnt    <= '0;
            row_cnt    <= '0;
            win_done_o <= 1'b0;
            win_last_o <= 1'b0;
        end else begin
            win_done_o <= col_done_i && interior;
            win_last_o <= col_done_i && last_row && last_col;
            if (col_done_i) begin
                if (last_col) begin
                    col_cnt <= '0;
                    // frame end wraps the row as well
                    row_cnt <= last_row ? '0 : row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    assign win_nw_o = top_q[0];
    assign win_n_o  = top_q[1];
    assign win_ne_o = top_q[2];
    assign win_w_o  = mid_q[0];
    assign win_c_o  = mid_q[1];
    assign win_e_o  = mid_q[2];
    assign win_sw_o = bot_q[0];
    assign win_s_o  = bot_q[1];
    assign win_se_o = bot_q[2];

endmodule

// File: hw/lbp_encoder.sv
`timescale 1ns/1ps

module lbp_encoder (
    input  logic            clk,
    input  logic            reset_i,
    input  img_pkg::pixel_t win_nw_i,
    input  img_pkg::pixel_t win_n_i,
    input  img_pkg::pixel_t win_ne_i,
    input  img_pkg::pixel_t win_w_i,
    input  img_pkg::pixel_t win_c_i,
    input  img_pkg::pixel_t win_e_i,
    input  img_pkg::pixel_t win_sw_i,
    input  img_pkg::pixel_t win_s_i,
    input  img_pkg::pixel_t win_se_i,
    input  logic            win_done_i,
    input  logic            win_last_i,
    output lbp_pkg::code_t  sign_code_o,
    output lbp_pkg::code_t  ni_code_o,
    output logic            code_done_o,
    output logic            frame_done_o
);

    img_pkg::pixel_t  nb [0:lbp_pkg::NEIGHBORS-1];
    lbp_pkg::sum_t    win_sum;
    lbp_pkg::code_t   sign_bits;
    lbp_pkg::scaled_t nb_x9 [0:lbp_pkg::NEIGHBORS-1];
    lbp_pkg::code_t   ni_bits;

    // stage one registers
    lbp_pkg::sum_t    sum_q;
    lbp_pkg::code_t   sign_q;
    lbp_pkg::scaled_t scaled_q [0:lbp_pkg::NEIGHBORS-1];
    logic             done_q;
    logic             last_q;

    // neighbors placed in code bit order
    assign nb[lbp_pkg::NB_E]  = win_e_i;
    assign nb[lbp_pkg::NB_NE] = win_ne_i;
    assign nb[lbp_pkg::NB_N]  = win_n_i;
    assign nb[lbp_pkg::NB_NW] = win_nw_i;
    assign nb[lbp_pkg::NB_W]  = win_w_i;
    assign nb[lbp_pkg::NB_SW] = win_sw_i;
    assign nb[lbp_pkg::NB_S]  = win_s_i;
    assign nb[lbp_pkg::NB_SE] = win_se_i;

    always_comb begin
        win_sum = lbp_pkg::sum_t'(win_c_i);
        for (int k = 0; k < lbp_pkg::NEIGHBORS; k++) begin
            win_sum      = win_sum + lbp_pkg::sum_t'(nb[k]);
            sign_bits[k] = (nb[k] >= win_c_i);
            // times nine as shift and add
            nb_x9[k]     = (lbp_pkg::scaled_t'(nb[k]) << 3) + lbp_pkg::scaled_t'(nb[k]);
        end
    end

    // neighbor >= sum / 9, rewritten as 9 * neighbor >= sum
    always_comb begin
        for (int k = 0; k < lbp_pkg::NEIGHBORS; k++) begin
            ni_bits[k] = (scaled_q[k] >= sum_q);
        end
    end

    always_ff @(posedge clk) begin
        if (win_done_i) begin
            sum_q  <= win_sum;
            sign_q <= sign_bits;
            for (int k = 0; k < lbp_pkg::NEIGHBORS; k++) begin
                scaled_q[k] <= nb_x9[k];
            end
        end
        if (done_q) begin
            sign_code_o <= sign_q;
            ni_code_o   <= ni_bits;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            done_q       <= 1'b0;
            last_q       <= 1'b0;
            code_done_o  <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            done_q       <= win_done_i;
            last_q       <= win_last_i;
            code_done_o  <= done_q;
            frame_done_o <= done_q && last_q;
        end
    end

endmodule

// File: hw/texture_top.sv
`timescale 1ns/1ps

module texture_top (
    input  logic            clk,
    input  logic            reset_i,
    input  img_pkg::pixel_t pix_i,
    input  logic            done_i,
    output lbp_pkg::code_t  sign_code_o,
    output lbp_pkg::code_t  ni_code_o,
    output logic            code_done_o,
    output logic            frame_done_o
);

    // three-pixel column from the row buffer
    img_pkg::pixel_t col_top;
    img_pkg::pixel_t col_mid;
    img_pkg::pixel_t col_bot;
    logic            col_done;

    // current 3x3 window
    img_pkg::pixel_t win_nw;
    img_pkg::pixel_t win_n;
    img_pkg::pixel_t win_ne;
    img_pkg::pixel_t win_w;
    img_pkg::pixel_t win_c;
    img_pkg::pixel_t win_e;
    img_pkg::pixel_t win_sw;
    img_pkg::pixel_t win_s;
    img_pkg::pixel_t win_se;
    logic            win_done;
    logic            win_last;

    row_buffer u_row_buffer (
        .clk        (clk),
        .reset_i    (reset_i),
        .pix_i      (pix_i),
        .done_i     (done_i),
        .col_top_o  (col_top),
        .col_mid_o  (col_mid),
        .col_bot_o  (col_bot),
        .col_done_o (col_done)
    );

    window_3x3 u_window (
        .clk        (clk),
        .reset_i    (reset_i),
        .col_top_i  (col_top),
        .col_mid_i  (col_mid),
        .col_bot_i  (col_bot),
        .col_done_i (col_done),
        .win_nw_o   (win_nw),
        .win_n_o    (win_n),
        .win_ne_o   (win_ne),
        .win_w_o    (win_w),
        .win_c_o    (win_c),
        .win_e_o    (win_e),
        .win_sw_o   (win_sw),
        .win_s_o    (win_s),
        .win_se_o   (win_se),
        .win_done_o (win_done),
        .win_last_o (win_last)
    );

    lbp_encoder u_encoder (
        .clk          (clk),
        .reset_i      (reset_i),
        .win_nw_i     (win_nw),
        .win_n_i      (win_n),
        .win_ne_i     (win_ne),
        .win_w_i      (win_w),
        .win_c_i      (win_c),
        .win_e_i      (win_e),
        .win_sw_i     (win_sw),
        .win_s_i      (win_s),
        .win_se_i     (win_se),
        .win_done_i   (win_done),
        .win_last_i   (win_last),
        .sign_code_o  (sign_code_o),
        .ni_code_o    (ni_code_o),
        .code_done_o  (code_done_o),
        .frame_done_o (frame_done_o)
    );

endmodule

// File: sim/tb_texture_top.sv
`timescale 1ns/1ps

module tb_texture_top;

    localparam int FRAME_PIX       = img_pkg::IMG_ROWS * img_pkg::IMG_COLS;
    localparam int LATENCY         = 4;
    localparam int DRAIN_LIMIT     = 50;
    // neighbor offsets in code bit order, east first and counter-clockwise
    localparam int ROW_OFF [0:7] = '{0, -1, -1, -1, 0, 1, 1, 1};
    localparam int COL_OFF [0:7] = '{1, 1, 0, -1, -1, -1, 0, 1};

    logic            clk;
    logic            reset_i;
    img_pkg::pixel_t pix_i;
    logic            done_i;
    lbp_pkg::code_t  sign_code_o;
    lbp_pkg::code_t  ni_code_o;
    logic            code_done_o;
    logic            frame_done_o;

    img_pkg::pixel_t frame [0:img_pkg::IMG_ROWS-1][0:img_pkg::IMG_COLS-1];
    // expected codes in raster order of window centers
    lbp_pkg::code_t  exp_sign_q [$];
    lbp_pkg::code_t  exp_ni_q [$];
    int              exp_cycle_q [$];
    bit              exp_last_q [$];
    integer          seed;
    int              cycle;
    string           test_name;

    texture_top u_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .pix_i        (pix_i),
        .done_i       (done_i),
        .sign_code_o  (sign_code_o),
        .ni_code_o    (ni_code_o),
        .code_done_o  (code_done_o),
        .frame_done_o (frame_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s expected 0x%0h actual 0x%0h", name, exp, act));
        end
    endtask

    // window completed by pixel (r, c) is centered one row and column back
    task automatic push_expected(input int r, input int c, input bit flat);
        int             cr;
        int             cc;
        int             ctr;
        int             sum;
        int             nb;
        lbp_pkg::code_t sign;
        lbp_pkg::code_t ni;
        cr  = r - 1;
        cc  = c - 1;
        ctr = frame[cr][cc];
        sum = ctr;
        for (int k = 0; k < 8; k++) begin
            sum = sum + frame[cr + ROW_OFF[k]][cc + COL_OFF[k]];
        end
        for (int k = 0; k < 8; k++) begin
            nb      = frame[cr + ROW_OFF[k]][cc + COL_OFF[k]];
            sign[k] = (nb >= ctr);
            // not below the mean, both sides scaled by nine
            ni[k]   = (nb * 9 >= sum);
        end
        // equal pixels set every bit under both rules
        if (flat) begin
            sign = 8'hff;
            ni   = 8'hff;
        end
        exp_sign_q.push_back(sign);
        exp_ni_q.push_back(ni);
        exp_cycle_q.push_back(cycle + LATENCY);
        exp_last_q.push_back(r == img_pkg::IMG_ROWS - 1 && c == img_pkg::IMG_COLS - 1);
    endtask

    task automatic send_frame(input bit gaps, input bit flat, input int n_pix);
        img_pkg::pixel_t level;
        int              r;
        int              c;
        level = img_pkg::pixel_t'($random(seed));
        for (int i = 0; i < FRAME_PIX; i++) begin
            frame[i / img_pkg::IMG_COLS][i % img_pkg::IMG_COLS] =
                flat ? level : img_pkg::pixel_t'($random(seed));
        end
        for (int i = 0; i < n_pix; i++) begin
            r = i / img_pkg::IMG_COLS;
            c = i % img_pkg::IMG_COLS;
            if (gaps) begin
                repeat ($random(seed) & 3) begin
                    @(negedge clk);
                    done_i <= 1'b0;
                    pix_i  <= img_pkg::pixel_t'($random(seed));
                end
            end
            @(negedge clk);
            done_i <= 1'b1;
            pix_i  <= frame[r][c];
            if (r >= 2 && c >= 2) begin
                push_expected(r, c, flat);
            end
        end
    endtask

    task automatic finish_test();
        int waited;
        @(negedge clk);
        done_i <= 1'b0;
        waited = 0;
        while (exp_sign_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_sign_q.size() != 0) begin
            fail_run($sformatf("timeout in %s: code_done_o never arrived for %0d codes",
                               test_name, exp_sign_q.size()));
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_i <= 1'b1;
        done_i  <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check({test_name, " code_done_o in reset"}, 0, code_done_o);
            // codes still in the pipeline are squashed
            exp_sign_q.delete();
            exp_ni_q.delete();
            exp_cycle_q.delete();
            exp_last_q.delete();
        end
        reset_i <= 1'b0;
    endtask

    always @(negedge clk) begin : code_monitor
        bit last_exp;
        if (code_done_o === 1'b1) begin
            if (exp_sign_q.size() == 0) begin
                fail_run($sformatf("%s: code_done_o pulsed with no code expected", test_name));
            end else begin
                check({test_name, " sign code"}, exp_sign_q.pop_front(), sign_code_o);
                check({test_name, " ni code"}, exp_ni_q.pop_front(), ni_code_o);
                check({test_name, " code cycle"}, exp_cycle_q.pop_front(), cycle);
                last_exp = exp_last_q.pop_front();
                check({test_name, " frame_done_o"}, last_exp, frame_done_o);
            end
        end else if (frame_done_o === 1'b1) begin
            fail_run($sformatf("%s: frame_done_o pulsed without code_done_o", test_name));
        end
    end

    initial begin
        seed        = 32'h851e_f754;
        cycle       = 0;
        reset_i     = 1'b1;
        done_i      = 1'b0;
        pix_i       = '0;
        test_name   = "power_on_reset";
        apply_reset();

        test_name = "full_rate";
        send_frame(1'b0, 1'b0, FRAME_PIX);
        finish_test();

        test_name = "random_gaps";
        send_frame(1'b1, 1'b0, FRAME_PIX);
        finish_test();

        test_name = "flat_frame";
        send_frame(1'b0, 1'b1, FRAME_PIX);
        finish_test();

        test_name = "back_to_back";
        send_frame(1'b0, 1'b0, FRAME_PIX);
        send_frame(1'b0, 1'b0, FRAME_PIX);
        finish_test();

        // reset lands with the row counter part way down the frame
        test_name = "mid_frame_reset";
        send_frame(1'b0, 1'b0, 5 * img_pkg::IMG_COLS + 7);
        apply_reset();
        send_frame(1'b0, 1'b0, FRAME_PIX);
        finish_test();

        $display("All tests passed");
        $finish;
    end

endmodule

// File: project.f
hw/img_pkg.sv
hw/lbp_pkg.sv
hw/row_buffer.sv
hw/window_3x3.sv
hw/lbp_encoder.sv
hw/texture_top.sv
sim/tb_texture_top.sv

// File: Makefile
# Verilator simulation of the texture code pipeline

TOP := tb_texture_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for a pass"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f project.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
